// File: list.f
+incdir+verilog
verilog/conv_pkg.sv
verilog/conv_ctrl.sv
verilog/conv_mac.sv
verilog/conv_accum.sv
verilog/conv_layer.sv
bench/conv_layer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the conv_layer testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module conv_layer_tb -o conv_layer_sim

./obj_dir/conv_layer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation result: pass"
  exit 0
else
  echo "Simulation result: fail"
  exit 1
fi

// File: bench/conv_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module conv_layer_tb
  import conv_pkg::*;
();

  localparam int NUM_TESTS = 5;
  localparam int MAX_CH    = 8;
  localparam int MAX_PIX   = 1024;

  logic                    clk;
  logic                    xrst;
  core_state_t             core_state;
  ctrl_reg                 in_ctrl;
  logic [`CONV_DWIDTH-1:0] in_pixel;
  logic [`CONV_DWIDTH-1:0] in_weight;
  logic [`CONV_LWIDTH-1:0] fea_height;
  logic [`CONV_LWIDTH-1:0] fea_width;
  logic                    first_input;
  logic                    last_input;
  logic                    out_ready;
  ctrl_reg                 out_ctrl;
  logic [`CONV_AWIDTH-1:0] out_data;

  // Test table, one row per layer
  string      names      [NUM_TESTS];
  logic [7:0] heights    [NUM_TESTS];
  logic [7:0] widths     [NUM_TESTS];
  int         channels   [NUM_TESTS];
  logic       rand_ready [NUM_TESTS];

  logic [7:0]  weights [MAX_CH];
  logic [7:0]  pixels  [MAX_CH][MAX_PIX];
  logic [23:0] exp_sum [MAX_PIX];   // Model sums in raster order

  int    seed = 63801;
  string cur_name = "reset";
  int    n_expected = 0;
  int    valid_cnt = 0;
  int    start_cnt = 0;
  int    stop_cnt = 0;
  logic  stop_seen = 1'b0;
  int    mismatch_errors = 0;
  int    protocol_errors = 0;
  int    cycle_count = 0;
  int    cycle_limit = 0;

  conv_layer uut (
    .clk         (clk),
    .xrst        (xrst),
    .core_state  (core_state),
    .in_ctrl     (in_ctrl),
    .in_pixel    (in_pixel),
    .in_weight   (in_weight),
    .fea_height  (fea_height),
    .fea_width   (fea_width),
    .first_input (first_input),
    .last_input  (last_input),
    .out_ready   (out_ready),
    .out_ctrl    (out_ctrl),
    .out_data    (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Ends a run that stalls, for instance when a stop strobe never arrives
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles while running %s", cycle_count, cur_name);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic add_row(input int idx, input string name, input logic [7:0] h,
                         input logic [7:0] w, input int ch, input logic rnd);
    names[idx]      = name;
    heights[idx]    = h;
    widths[idx]     = w;
    channels[idx]   = ch;
    rand_ready[idx] = rnd;
  endtask

  function automatic ctrl_reg make_strobe(input logic start_bit, input logic valid_bit,
                                          input logic stop_bit);
    ctrl_reg s;
    s.start = start_bit;
    s.valid = valid_bit;
    s.stop  = stop_bit;
    return s;
  endfunction

  function automatic logic next_ready(input logic rnd);
    logic [31:0] r;
    r = $random(seed);
    return rnd ? r[0] : 1'b1;
  endfunction

  // Looks at the outputs as they stood during the cycle that just ended
  task automatic check_outputs();
    if (out_ctrl.valid === 1'b1 && (xrst !== 1'b1 || core_state == CORE_INPUT)) begin
      $display("%s: output valid seen during reset or input phase", cur_name);
      protocol_errors++;
    end
    if (out_ctrl.valid === 1'b1) begin
      if (start_cnt == 0) begin
        $display("%s: output valid came before the start pulse", cur_name);
        protocol_errors++;
      end
      if (valid_cnt >= n_expected) begin
        $display("%s: more valid outputs than pixels in the frame", cur_name);
        protocol_errors++;
      end else if (out_data !== exp_sum[valid_cnt]) begin
        $display("mismatch %s pixel %0d: expected %06h, actual %06h",
                 cur_name, valid_cnt, exp_sum[valid_cnt], out_data);
        mismatch_errors++;
      end
      valid_cnt++;
    end
    if (out_ctrl.start === 1'b1) begin
      if (valid_cnt != 0) begin
        $display("%s: start pulse arrived after results had begun", cur_name);
        protocol_errors++;
      end
      start_cnt++;
    end
    if (out_ctrl.stop === 1'b1) begin
      stop_cnt++;
      stop_seen = 1'b1;
      if (out_ctrl.valid !== 1'b1) begin
        $display("%s: stop pulse without a valid result", cur_name);
        protocol_errors++;
      end else if (valid_cnt != n_expected) begin
        $display("%s: stop pulse came with result %0d of %0d", cur_name, valid_cnt,
                 n_expected);
        protocol_errors++;
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    check_outputs();
  endtask

  // One channel frame: start with the weight, pixels, then stop
  task automatic send_frame(input int ch, input int n_ch, input int n_pix);
    next_cycle();
    in_ctrl     <= make_strobe(1'b1, 1'b0, 1'b0);
    in_weight   <= weights[ch];
    first_input <= (ch == 0);
    last_input  <= (ch == n_ch - 1);
    for (int p = 0; p < n_pix; p++) begin
      next_cycle();
      in_ctrl  <= make_strobe(1'b0, 1'b1, 1'b0);
      in_pixel <= pixels[ch][p];
    end
    next_cycle();
    in_ctrl <= make_strobe(1'b0, 1'b0, 1'b1);
    next_cycle();
    in_ctrl <= '0;
  endtask

  task automatic run_layer(input int t);
    int          n;
    logic [31:0] acc;
    cur_name = names[t];
    n = int'(heights[t]) * int'(widths[t]);
    for (int c = 0; c < channels[t]; c++) begin
      weights[c] = 8'($random(seed));
      for (int p = 0; p < n; p++)
        pixels[c][p] = 8'($random(seed));
    end
    for (int p = 0; p < n; p++) begin
      acc = '0;
      for (int c = 0; c < channels[t]; c++)
        acc = acc + 32'(pixels[c][p]) * 32'(weights[c]);
      exp_sum[p] = acc[23:0];   // Sums wrap at 2^24
    end
    n_expected = n;
    valid_cnt  = 0;
    start_cnt  = 0;
    stop_cnt   = 0;
    stop_seen  = 1'b0;

    next_cycle();
    fea_height <= heights[t];
    fea_width  <= widths[t];
    core_state <= CORE_INPUT;
    out_ready  <= 1'b1;
    for (int c = 0; c < channels[t]; c++)
      send_frame(c, channels[t], n);

    next_cycle();
    core_state <= CORE_OUTPUT;
    out_ready  <= next_ready(rand_ready[t]);
    while (!stop_seen) begin
      next_cycle();
      out_ready <= next_ready(rand_ready[t]);
    end
    repeat (6) next_cycle();   // Nothing more may follow the stop
    core_state <= CORE_WAIT;
    out_ready  <= 1'b0;
    next_cycle();

    if (valid_cnt != n) begin
      $display("mismatch %s valid count: expected %0d, actual %0d", cur_name, n, valid_cnt);
      mismatch_errors++;
    end
    if (start_cnt != 1) begin
      $display("%s: saw %0d output start pulses instead of one", cur_name, start_cnt);
      protocol_errors++;
    end
    if (stop_cnt != 1) begin
      $display("%s: saw %0d output stop pulses instead of one", cur_name, stop_cnt);
      protocol_errors++;
    end
  endtask

  initial begin
    xrst        <= 1'b0;
    core_state  <= CORE_WAIT;
    in_ctrl     <= '0;
    in_pixel    <= '0;
    in_weight   <= '0;
    fea_height  <= '0;
    fea_width   <= '0;
    first_input <= 1'b0;
    last_input  <= 1'b0;
    out_ready   <= 1'b0;

    add_row(0, "basic_4x4_3ch",        8'd4, 8'd4,  3, 1'b0);
    add_row(1, "smaller_3x5_2ch",      8'd3, 8'd5,  2, 1'b0);   // Must not see row 0
    add_row(2, "backpressure_6x6_4ch", 8'd6, 8'd6,  4, 1'b1);
    add_row(3, "single_8x4_1ch",       8'd8, 8'd4,  1, 1'b1);
    add_row(4, "wide_2x16_5ch",        8'd2, 8'd16, 5, 1'b0);

    for (int t = 0; t < NUM_TESTS; t++)
      cycle_limit = cycle_limit
                  + 2 * (channels[t] + 1) * int'(heights[t]) * int'(widths[t]);
    cycle_limit = cycle_limit + 100;

    repeat (2) next_cycle();
    xrst <= 1'b1;
    next_cycle();

    for (int t = 0; t < NUM_TESTS; t++)
      run_layer(t);

    $display("Finished with %0d mismatches and %0d protocol errors",
             mismatch_errors, protocol_errors);
    if (mismatch_errors == 0 && protocol_errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/conv_layer.sv
`default_nettype none
`timescale 1ns/1ps

`include "conv_config.svh"

module conv_layer
  import conv_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    xrst,
  input  wire core_state_t             core_state,
  input  wire ctrl_reg                 in_ctrl,
  input  wire logic [`CONV_DWIDTH-1:0] in_pixel,
  input  wire logic [`CONV_DWIDTH-1:0] in_weight,
  input  wire logic [`CONV_LWIDTH-1:0] fea_height,
  input  wire logic [`CONV_LWIDTH-1:0] fea_width,
  input  wire logic                    first_input,
  input  wire logic                    last_input,
  input  wire logic                    out_ready,
  output wire ctrl_reg                 out_ctrl,
  output wire logic [`CONV_AWIDTH-1:0] out_data
);

  mem_feat_ctrl            mem_feat;
  logic                    conv_oe;
  logic [`CONV_AWIDTH-1:0] product;

  // Decode: sequencing, addresses and strobe alignment
  conv_ctrl u_ctrl (
    .clk         (clk),
    .xrst        (xrst),
    .in_ctrl     (in_ctrl),
    .core_state  (core_state),
    .fea_height  (fea_height),
    .fea_width   (fea_width),
    .first_input (first_input),
    .last_input  (last_input),
    .out_ready   (out_ready),
    .out_ctrl    (out_ctrl),
    .mem_feat    (mem_feat),
    .conv_oe     (conv_oe)
  );

  conv_mac u_mac (
    .clk       (clk),
    .xrst      (xrst),
    .in_ctrl   (in_ctrl),
    .in_pixel  (in_pixel),
    .in_weight (in_weight),
    .product   (product)
  );

  conv_accum u_accum (
    .clk      (clk),
    .xrst     (xrst),
    .mem_feat (mem_feat),
    .product  (product),
    .conv_oe  (conv_oe),
    .out_data (out_data)
  );

endmodule

`default_nettype wire

// File: verilog/conv_accum.sv
`default_nettype none
`timescale 1ns/1ps

`include "conv_config.svh"

module conv_accum
  import conv_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    xrst,
  input  wire mem_feat_ctrl            mem_feat,
  input  wire logic [`CONV_AWIDTH-1:0] product,
  input  wire logic                    conv_oe,
  output logic      [`CONV_AWIDTH-1:0] out_data
);

  localparam int AW      = `CONV_AWIDTH;
  localparam int DEPTH   = 1 << `CONV_FACCUM;
  localparam int D_ACCUM = `CONV_D_ACCUM;

  logic [AW-1:0] mem [DEPTH];
  logic [AW-1:0] rdata;
  logic [AW-1:0] wdata;
  logic [AW-1:0] rd_pipe [D_ACCUM-1];

  // Running sum per pixel position, restarted by the first channel
  assign wdata = mem_feat.rst ? product : rdata + product;

  // The read word for a pixel lands in the same cycle as its product
  always_ff @(posedge clk) begin
    if (mem_feat.we)
      mem[mem_feat.waddr] <= wdata;
    rdata <= mem[mem_feat.raddr];
  end

  // Drain path from the read register to the output register
  always_ff @(posedge clk) begin
    rd_pipe[0] <= rdata;
    for (int i = 1; i < D_ACCUM-1; i++)
      rd_pipe[i] <= rd_pipe[i-1];
  end

  // Holds each result for the cycle where out_ctrl.valid is high
  always_ff @(posedge clk) begin
    if (!xrst)
      out_data <= '0;
    else if (conv_oe)
      out_data <= rd_pipe[D_ACCUM-2];
  end

endmodule

`default_nettype wire

// File: verilog/conv_mac.sv
`default_nettype none
`timescale 1ns/1ps

`include "conv_config.svh"

module conv_mac
  import conv_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    xrst,
  input  wire ctrl_reg                 in_ctrl,
  input  wire logic [`CONV_DWIDTH-1:0] in_pixel,
  input  wire logic [`CONV_DWIDTH-1:0] in_weight,
  output logic      [`CONV_AWIDTH-1:0] product
);

  localparam int AW     = `CONV_AWIDTH;
  localparam int D_CONV = `CONV_D_CONV;

  logic [`CONV_DWIDTH-1:0] weight_q;
  logic [`CONV_DWIDTH-1:0] pixel_q;
  logic [AW-1:0]           prod_d [D_CONV-1];

  // One weight per channel frame, taken with the start strobe
  always_ff @(posedge clk) begin
    if (!xrst)
      weight_q <= '0;
    else if (in_ctrl.start)
      weight_q <= in_weight;
  end

  // First stage holds the pixel
  always_ff @(posedge clk) begin
    if (in_ctrl.valid)
      pixel_q <= in_pixel;
  end

  // Second stage holds the product, zero extended to the sum width
  always_ff @(posedge clk) begin
    prod_d[0] <= AW'(pixel_q) * AW'(weight_q);
    for (int i = 1; i < D_CONV-1; i++)
      prod_d[i] <= prod_d[i-1];   // Extra stages for a deeper multiplier
  end

  assign product = prod_d[D_CONV-2];

endmodule

`default_nettype wire

// File: verilog/conv_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "conv_config.svh"

module conv_ctrl
  import conv_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    xrst,
  input  wire ctrl_reg                 in_ctrl,
  input  wire core_state_t             core_state,
  input  wire logic [`CONV_LWIDTH-1:0] fea_height,
  input  wire logic [`CONV_LWIDTH-1:0] fea_width,
  input  wire logic                    first_input,
  input  wire logic                    last_input,
  input  wire logic                    out_ready,
  output ctrl_reg                      out_ctrl,
  output mem_feat_ctrl                 mem_feat,
  output logic                         conv_oe
);

  localparam int D_CONV = `CONV_D_CONV;
  localparam int D_OUT  = `CONV_D_CONV + `CONV_D_ACCUM;

  ctrl_state_t             state;
  core_state_t             core_q;
  logic                    first_q;
  logic                    last_q;
  logic [`CONV_LWIDTH-1:0] height_q;
  logic [`CONV_LWIDTH-1:0] width_q;
  logic [`CONV_LWIDTH-1:0] conv_x;
  logic [`CONV_LWIDTH-1:0] conv_y;
  logic                    last_x;
  logic                    last_y;
  logic                    finished;
  logic                    rd_issue;
  logic                    in_pixel;
  logic                    we_d   [D_CONV];
  logic                    rst_d  [D_CONV];
  logic [`CONV_FACCUM-1:0] addr_d [D_CONV+1];   // Index 0 is the base address
  ctrl_reg                 out_d  [D_OUT];

  // Active from the first channel start until the last result leaves
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= CTRL_WAIT;
    end else begin
      case (state)
        CTRL_WAIT: begin
          if (in_ctrl.start)
            state <= CTRL_ACTIVE;
        end
        CTRL_ACTIVE: begin
          if (out_ctrl.stop)
            state <= CTRL_WAIT;
        end
        default: state <= CTRL_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      core_q  <= CORE_WAIT;
      first_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      core_q  <= core_state;
      first_q <= first_input;
      last_q  <= last_input;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      height_q <= '0;
      width_q  <= '0;
    end else if (in_ctrl.start) begin
      height_q <= fea_height;
      width_q  <= fea_width;
    end
  end

  assign last_x   = conv_x == width_q - 1'b1;
  assign last_y   = conv_y == height_q - 1'b1;
  assign in_pixel = core_q == CORE_INPUT && in_ctrl.valid;

  // One read per cycle while draining, held off by the downstream ready level
  assign rd_issue = state == CTRL_ACTIVE && core_q == CORE_OUTPUT
                 && !finished && out_ready;

  // Raster position of the next read over the output frame
  always_ff @(posedge clk) begin
    if (!xrst) begin
      conv_x <= '0;
      conv_y <= '0;
    end else if (state != CTRL_ACTIVE || core_q != CORE_OUTPUT) begin
      conv_x <= '0;
      conv_y <= '0;
    end else if (rd_issue) begin
      if (last_x) begin
        conv_x <= '0;
        conv_y <= last_y ? '0 : conv_y + 1'b1;
      end else begin
        conv_x <= conv_x + 1'b1;
      end
    end
  end

  // Set once the last coordinate has been read, cleared by the next frame start
  always_ff @(posedge clk) begin
    if (!xrst)
      finished <= 1'b0;
    else if (in_ctrl.start)
      finished <= 1'b0;
    else if (rd_issue && last_x && last_y)
      finished <= 1'b1;
  end

  // Base address and its copies, lined up with the multiply pipeline
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < D_CONV; i++) begin
        we_d[i]  <= 1'b0;
        rst_d[i] <= 1'b0;
      end
      for (int i = 0; i <= D_CONV; i++)
        addr_d[i] <= '0;
    end else begin
      if (in_ctrl.stop || finished)
        addr_d[0] <= '0;
      else if (in_pixel || rd_issue)
        addr_d[0] <= addr_d[0] + 1'b1;

      we_d[0]  <= in_pixel;
      rst_d[0] <= in_pixel && first_q;   // First channel replaces the stale sums
      for (int i = 1; i < D_CONV; i++) begin
        we_d[i]  <= we_d[i-1];
        rst_d[i] <= rst_d[i-1];
      end
      for (int i = 1; i <= D_CONV; i++)
        addr_d[i] <= addr_d[i-1];
    end
  end

  // Read one cycle behind the base address, write when the product is ready
  assign mem_feat = '{
    we:    we_d[D_CONV-1],
    rst:   rst_d[D_CONV-1],
    waddr: addr_d[D_CONV],
    raddr: addr_d[D_CONV-1]
  };

  // Output strobes travel alongside the read data through the accumulator
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < D_OUT; i++)
        out_d[i] <= '0;
    end else begin
      out_d[0].start <= state == CTRL_ACTIVE && in_ctrl.stop && last_q;
      out_d[0].valid <= rd_issue;
      out_d[0].stop  <= rd_issue && last_x && last_y;
      for (int i = 1; i < D_OUT; i++)
        out_d[i] <= out_d[i-1];
    end
  end

  assign out_ctrl = out_d[D_OUT-1];
  assign conv_oe  = out_d[D_OUT-2].valid;   // Loads out_data a cycle ahead of valid

endmodule

`default_nettype wire

// File: verilog/conv_pkg.sv
`default_nettype none

`include "conv_config.svh"

package conv_pkg;

  // Plain strobes that frame a stream of pixels
  typedef struct packed {
    logic start;   // One pulse ahead of the first pixel
    logic valid;   // One per pixel
    logic stop;    // One pulse after the last pixel
  } ctrl_reg;

  // Layer phase driven by the outside sequencer
  typedef enum logic [1:0] {
    CORE_WAIT    = 2'd0,
    CORE_NETWORK = 2'd1,
    CORE_INPUT   = 2'd2,
    CORE_OUTPUT  = 2'd3
  } core_state_t;

  typedef enum logic {
    CTRL_WAIT   = 1'b0,
    CTRL_ACTIVE = 1'b1
  } ctrl_state_t;

  // Feature memory port, already aligned to the datapath
  typedef struct packed {
    logic                    we;
    logic                    rst;     // Overwrite instead of accumulate
    logic [`CONV_FACCUM-1:0] waddr;
    logic [`CONV_FACCUM-1:0] raddr;
  } mem_feat_ctrl;

endpackage

`default_nettype wire

// File: verilog/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// Frame height, width and pixel coordinates
`define CONV_LWIDTH 8

// Pixels and weights, both unsigned
`define CONV_DWIDTH 8

// Products and running sums, which wrap at 2^24
`define CONV_AWIDTH 24

// Feature memory address, enough for 1024 pixels per frame
`define CONV_FACCUM 10

`define CONV_D_CONV  2   // Multiply pipeline stages
`define CONV_D_ACCUM 2   // Accumulator read to output register

`endif
